//--- sources.f
design/soc_pkg.sv
design/mac_lane.sv
design/gemm_requant.sv
design/gemm_ctrl.sv
design/banked_memory.sv
design/seg_display.sv
design/soc_top.sv
bench/soc_checker.sv
bench/soc_tb.sv

//--- bench/soc_tb.sv
`default_nettype none

module soc_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import soc_pkg::*;

  localparam int poll_limit = 100;
  localparam int run_cycles = 22; // start strobe to the first status read showing done.
  localparam int scan_limit = 9 * 8192; // a full sweep of the digits and some margin.
  localparam int a_line = 'h10;
  localparam int b_line = 'h11;
  localparam int c_line = 'h12;

  logic            clk, reset;
  logic            bus_en, bus_rdwr;
  logic [31:0]     bus_addr, bus_wr_data, bus_rd_data;
  logic [3:0]      bus_mask;
  logic [7:0]      an;
  logic [6:0]      a_to_g;
  logic [31:0]     exp_rd, disp_shadow, rng;
  logic            rd_check, disp_check, timed_out;
  logic [8*12-1:0] test_name;
  int              fail_count, errs_at_start, reads_checked, tests_run;
  logic [31:0]     shadow [8];
  logic [7:0]      a_bytes [16];
  logic [7:0]      b_bytes [16];

  soc_top u_dut (
    .clk(clk), .reset(reset), .bus_en(bus_en), .bus_rdwr(bus_rdwr), .bus_addr(bus_addr),
    .bus_wr_data(bus_wr_data), .bus_mask(bus_mask), .bus_rd_data(bus_rd_data),
    .an(an), .a_to_g(a_to_g)
  );

  soc_checker u_chk (
    .clk(clk), .reset(reset), .bus_en(bus_en), .bus_rdwr(bus_rdwr),
    .bus_rd_data(bus_rd_data), .exp_rd(exp_rd), .rd_check(rd_check), .an(an),
    .a_to_g(a_to_g), .disp_shadow(disp_shadow), .disp_check(disp_check),
    .test_name(test_name), .fail_count(fail_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [31:0] mem_addr(input int line, input int word);
    return (line << 4) | (word << 2);
  endfunction

  function automatic logic [31:0] gemm_addr(input logic [4:0] offset);
    return {gemm_region, 23'd0, offset};
  endfunction

  // single cycle strobes driven 1 ns after a rising edge.
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] mask);
    bus_en = 1'b1;
    bus_rdwr = 1'b1;
    bus_addr = addr;
    bus_wr_data = data;
    bus_mask = mask;
    @(posedge clk);
    #1;
    bus_en = 1'b0;
    bus_rdwr = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp,
                          input logic check, output logic [31:0] data);
    bus_en = 1'b1;
    bus_rdwr = 1'b0;
    bus_addr = addr;
    exp_rd = exp;
    rd_check = check;
    @(posedge clk);
    #1;
    bus_en = 1'b0;
    rd_check = 1'b0;
    data = bus_rd_data;
    if (check) reads_checked++;
  endtask

  task automatic start_test(input logic [8*12-1:0] name);
    test_name = name;
    errs_at_start = fail_count;
  endtask

  task automatic end_test();
    repeat (2) @(posedge clk); // let the last read check land.
    #1;
    tests_run++;
    $display("test %0s: %0d errors", test_name, fail_count - errs_at_start);
  endtask

  task automatic test_mem_mask();
    logic [31:0] data, wdata, r;
    logic [3:0]  mask;
    start_test("mem_mask");
    for (int w = 0; w < 8; w++) begin
      shadow[w] = next_rand();
      bus_write(mem_addr('h40 + w / 4, w % 4), shadow[w], 4'hf);
    end
    for (int n = 0; n < 16; n++) begin
      wdata = next_rand();
      r = next_rand();
      mask = r[3:0];
      bus_write(mem_addr('h40 + (n % 8) / 4, n % 4), wdata, mask);
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) shadow[n % 8][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    for (int w = 0; w < 8; w++) begin
      bus_read(mem_addr('h40 + w / 4, w % 4), shadow[w], 1'b1, data);
    end
    end_test();
  endtask

  task automatic test_gemm_regs();
    logic [31:0] data;
    logic [31:0] vals [4];
    logic [4:0]  offs [4];
    start_test("gemm_regs");
    offs = '{reg_a_addr, reg_b_addr, reg_c_addr, reg_shift};
    for (int n = 0; n < 4; n++) begin
      vals[n] = next_rand();
      bus_write(gemm_addr(offs[n]), vals[n], 4'hf);
    end
    for (int n = 0; n < 4; n++) begin
      bus_read(gemm_addr(offs[n]), vals[n] & (n == 3 ? 32'h1f : 32'h7ff), 1'b1, data);
    end
    bus_read(gemm_addr(reg_ctrl), 32'h0, 1'b1, data);
    end_test();
  endtask

  task automatic load_operands(input int shift);
    logic [31:0] wa, wb;
    for (int w = 0; w < 4; w++) begin
      wa = next_rand();
      wb = next_rand();
      bus_write(mem_addr(a_line, w), wa, 4'hf);
      bus_write(mem_addr(b_line, w), wb, 4'hf);
      for (int n = 0; n < 4; n++) begin
        a_bytes[4*w + n] = wa[n*8 +: 8];
        b_bytes[4*w + n] = wb[n*8 +: 8];
      end
    end
    bus_write(gemm_addr(reg_a_addr), a_line, 4'hf);
    bus_write(gemm_addr(reg_b_addr), b_line, 4'hf);
    bus_write(gemm_addr(reg_c_addr), c_line, 4'hf);
    bus_write(gemm_addr(reg_shift), shift, 4'hf);
  endtask

  task automatic run_gemm();
    logic [31:0] data, exp;
    int          polls;
    bus_write(gemm_addr(reg_ctrl), 32'h1, 4'hf);
    bus_read(gemm_addr(reg_status), 32'h1, 1'b1, data);
    bus_write(gemm_addr(reg_ctrl), 32'h1, 4'hf); // ignored while the engine is busy.
    polls = 0;
    data = '0;
    while (!data[1] && polls < poll_limit) begin
      // first poll strobe lands three cycles after the start.
      exp = polls + 3 < run_cycles ? 32'h1 : 32'h2;
      bus_read(gemm_addr(reg_status), exp, 1'b1, data);
      polls++;
    end
    if (!data[1]) begin
      $display("gemm run not done after %0d status polls", poll_limit);
      timed_out = 1'b1;
    end else begin
      bus_read(gemm_addr(reg_status), 32'h2, 1'b1, data);
    end
  endtask

  // C[i][j] as signed sums, shifted and clamped to int8.
  task automatic check_result(input int shift);
    logic [31:0] exp, data;
    int          sum;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        sum = 0;
        for (int k = 0; k < 4; k++) begin
          sum += int'($signed(a_bytes[4*i + k])) * int'($signed(b_bytes[4*k + j]));
        end
        sum = sum >>> shift;
        sum = sum > 127 ? 127 : (sum < -128 ? -128 : sum);
        exp[j*8 +: 8] = sum[7:0];
      end
      bus_read(mem_addr(c_line, i), exp, 1'b1, data);
    end
  endtask

  task automatic test_gemm_result();
    int shifts [3];
    shifts = '{0, 4, 10};
    start_test("gemm_result");
    for (int s = 0; s < 3 && !timed_out; s++) begin
      load_operands(shifts[s]);
      run_gemm();
      if (!timed_out) check_result(shifts[s]);
    end
    end_test();
  endtask

  task automatic test_display();
    logic [31:0] data, wdata;
    logic [7:0]  digit_an;
    int          waited;
    start_test("display");
    disp_check = 1'b1;
    wdata = next_rand();
    bus_write({disp_region, 28'd0}, wdata, 4'hf);
    disp_shadow = wdata;
    wdata = next_rand();
    bus_write({disp_region, 28'd0}, wdata, 4'b0101);
    disp_shadow[7:0] = wdata[7:0];
    disp_shadow[23:16] = wdata[23:16];
    bus_read({disp_region, 28'd0}, disp_shadow, 1'b1, data);
    for (int d = 0; d < 8 && !timed_out; d++) begin
      digit_an = ~(8'b1 << d);
      waited = 0;
      while (an !== digit_an && waited < scan_limit) begin
        @(posedge clk);
        #1;
        waited++;
      end
      if (an !== digit_an) begin
        $display("digit %0d never selected within %0d cycles", d, scan_limit);
        timed_out = 1'b1;
      end
      repeat (2) @(posedge clk);
      #1;
    end
    end_test();
    disp_check = 1'b0;
  endtask

  initial begin
    reset = 1'b1;
    bus_en = 1'b0;
    bus_rdwr = 1'b0;
    bus_addr = '0;
    bus_wr_data = '0;
    bus_mask = '0;
    exp_rd = '0;
    rd_check = 1'b0;
    disp_check = 1'b0;
    disp_shadow = '0;
    timed_out = 1'b0;
    test_name = "reset";
    rng = 32'he772_defe;
    reads_checked = 0;
    tests_run = 0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    test_mem_mask();
    test_gemm_regs();
    start_test("gemm_status");
    load_operands(4);
    run_gemm();
    end_test();
    if (!timed_out) test_gemm_result();
    if (!timed_out) test_display();
    $display("%0d tests, %0d reads checked, %0d errors", tests_run, reads_checked, fail_count);
    if (timed_out || fail_count != 0) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/soc_checker.sv
`default_nettype none

module soc_checker (
  input  logic            clk,
  input  logic            reset,
  input  logic            bus_en,
  input  logic            bus_rdwr,
  input  logic [31:0]     bus_rd_data,
  input  logic [31:0]     exp_rd,
  input  logic            rd_check,
  input  logic [7:0]      an,
  input  logic [6:0]      a_to_g,
  input  logic [31:0]     disp_shadow,
  input  logic            disp_check,
  input  logic [8*12-1:0] test_name,
  output int              fail_count
);
  timeunit 1ns;
  timeprecision 100ps;

  // active low, segment a in the msb.
  localparam logic [6:0] seg_table [16] = '{
    7'h01, 7'h4f, 7'h12, 7'h06, 7'h4c, 7'h24, 7'h20, 7'h0f,
    7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h42, 7'h30, 7'h38
  };

  logic [31:0] exp_q; // expected word of the read issued last cycle.
  logic [2:0]  cur_digit;
  logic [6:0]  exp_seg;

  initial fail_count = 0;

  always_ff @(posedge clk) begin
    exp_q <= exp_rd;
  end

  always_comb begin
    cur_digit = 3'd0;
    for (int d = 0; d < 8; d++) begin
      if (!an[d]) cur_digit = 3'(d);
    end
    exp_seg = seg_table[disp_shadow[cur_digit*4 +: 4]];
  end

  a_read_data: assert property (
    @(posedge clk) disable iff (reset)
    (bus_en && !bus_rdwr && rd_check) |=> (bus_rd_data == exp_q)
  ) else begin
    fail_count++;
    $display("[ERROR] %0s: expected %h, actual %h", test_name, $sampled(exp_q),
             $sampled(bus_rd_data));
  end

  // whichever digit is lit must show its own nibble.
  a_segments: assert property (
    @(posedge clk) disable iff (reset || !disp_check)
    a_to_g == exp_seg
  ) else begin
    fail_count++;
    $display("[ERROR] %0s: digit %0d expected %b, actual %b", test_name,
             $sampled(cur_digit), $sampled(exp_seg), $sampled(a_to_g));
  end

endmodule

`default_nettype wire

//--- design/soc_top.sv
`default_nettype none

module soc_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        bus_en,
  input  logic        bus_rdwr,
  input  logic [31:0] bus_addr,
  input  logic [31:0] bus_wr_data,
  input  logic [3:0]  bus_mask,
  output logic [31:0] bus_rd_data,
  output logic [7:0]  an,
  output logic [6:0]  a_to_g
);
  import soc_pkg::*;

  logic                       is_gemm, is_disp;
  logic                       mem_en, gemm_en, disp_en;
  logic                       sel_gemm_q, sel_disp_q;
  logic [31:0]                mem_rd_data, gemm_rd_data, gemm_rd_q;
  logic [31:0]                disp_value, disp_rd_q;
  logic                       line_en, line_rdwr;
  logic [line_addr_width-1:0] line_addr;
  logic [line_width-1:0]      line_wr_data, line_rd_data;

  assign is_gemm = bus_addr[31:28] == gemm_region;
  assign is_disp = bus_addr[31:28] == disp_region;
  assign gemm_en = bus_en && is_gemm;
  assign disp_en = bus_en && is_disp;
  assign mem_en  = bus_en && !is_gemm && !is_disp; // everything else is memory.

  // register side returns align with the synchronous memory read.
  always_ff @(posedge clk) begin
    if (reset) begin
      sel_gemm_q <= 1'b0;
      sel_disp_q <= 1'b0;
    end else if (bus_en) begin
      sel_gemm_q <= is_gemm;
      sel_disp_q <= is_disp;
    end
  end

  always_ff @(posedge clk) begin
    gemm_rd_q <= gemm_rd_data;
    disp_rd_q <= disp_value;
  end

  assign bus_rd_data = sel_gemm_q ? gemm_rd_q :
                       sel_disp_q ? disp_rd_q : mem_rd_data;

  banked_memory u_mem (
    .clk          (clk),
    .reset        (reset),
    .bus_en       (mem_en),
    .bus_rdwr     (bus_rdwr),
    .bus_mask     (bus_mask),
    .bus_word     (bus_addr[3:2]),
    .bus_line     (bus_addr[14:4]),
    .bus_wr_data  (bus_wr_data),
    .bus_rd_data  (mem_rd_data),
    .line_en      (line_en),
    .line_rdwr    (line_rdwr),
    .line_addr    (line_addr),
    .line_wr_data (line_wr_data),
    .line_rd_data (line_rd_data)
  );

  gemm_ctrl u_gemm (
    .clk          (clk),
    .reset        (reset),
    .cfg_en       (gemm_en),
    .cfg_rdwr     (bus_rdwr),
    .cfg_offset   (bus_addr[4:0]),
    .cfg_wr_data  (bus_wr_data),
    .cfg_rd_data  (gemm_rd_data),
    .line_en      (line_en),
    .line_rdwr    (line_rdwr),
    .line_addr    (line_addr),
    .line_rd_data (line_rd_data),
    .line_wr_data (line_wr_data)
  );

  seg_display u_disp (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (disp_en && bus_rdwr),
    .wr_data (bus_wr_data),
    .wr_mask (bus_mask),
    .value   (disp_value),
    .an      (an),
    .a_to_g  (a_to_g)
  );

endmodule

`default_nettype wire

//--- design/seg_display.sv
`default_nettype none

module seg_display (
  input  logic        clk,
  input  logic        reset,
  input  logic        wr_en,
  input  logic [31:0] wr_data,
  input  logic [3:0]  wr_mask,
  output logic [31:0] value,
  output logic [7:0]  an,
  output logic [6:0]  a_to_g
);
  import soc_pkg::*;

  logic [scan_width-1:0] scan;
  logic [2:0]            digit;
  logic [3:0]            nibble;

  always_ff @(posedge clk) begin
    if (reset) begin
      value <= '0;
    end else if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wr_mask[b]) value[b*8 +: 8] <= wr_data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) scan <= '0;
    else       scan <= scan + 1'b1; // free running refresh.
  end

  assign digit  = scan[scan_width-1 -: 3];
  assign nibble = value[digit*4 +: 4];
  assign an     = ~(8'b1 << digit);

  // segments a..g, low lights.
  always_comb begin
    case (nibble)
      4'h0: a_to_g = 7'b0000001;
      4'h1: a_to_g = 7'b1001111;
      4'h2: a_to_g = 7'b0010010;
      4'h3: a_to_g = 7'b0000110;
      4'h4: a_to_g = 7'b1001100;
      4'h5: a_to_g = 7'b0100100;
      4'h6: a_to_g = 7'b0100000;
      4'h7: a_to_g = 7'b0001111;
      4'h8: a_to_g = 7'b0000000;
      4'h9: a_to_g = 7'b0000100;
      4'ha: a_to_g = 7'b0001000;
      4'hb: a_to_g = 7'b1100000;
      4'hc: a_to_g = 7'b0110001;
      4'hd: a_to_g = 7'b1000010;
      4'he: a_to_g = 7'b0110000;
      default: a_to_g = 7'b0111000;
    endcase
  end

  a_one_digit: assert property (
    @(posedge clk) disable iff (reset)
    $onehot(~an)
  );

endmodule

`default_nettype wire

//--- design/banked_memory.sv
`default_nettype none

module banked_memory (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                bus_en,
  input  logic                                bus_rdwr,
  input  logic [3:0]                          bus_mask,
  input  logic [1:0]                          bus_word,
  input  logic [soc_pkg::line_addr_width-1:0] bus_line,
  input  logic [31:0]                         bus_wr_data,
  output logic [31:0]                         bus_rd_data,
  input  logic                                line_en,
  input  logic                                line_rdwr,
  input  logic [soc_pkg::line_addr_width-1:0] line_addr,
  input  logic [soc_pkg::line_width-1:0]      line_wr_data,
  output logic [soc_pkg::line_width-1:0]      line_rd_data
);
  import soc_pkg::*;

  logic [line_width-1:0] word_q; // all banks as seen by the word port.
  logic [1:0]            rd_word;

  // word select of the pending read.
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_word <= 2'd0;
    end else if (bus_en && !bus_rdwr) begin
      rd_word <= bus_word;
    end
  end

  assign bus_rd_data = word_q[rd_word*32 +: 32];

  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    logic [7:0] ram [2**line_addr_width];
    logic       word_wr;

    // only the four banks of the addressed word, byte by byte.
    assign word_wr = bus_en && bus_rdwr && (bus_word == b / 4) && bus_mask[b % 4];

    always_ff @(posedge clk) begin
      if (word_wr) begin
        ram[bus_line] <= bus_wr_data[(b % 4)*8 +: 8];
      end
      if (line_en && line_rdwr) begin
        ram[line_addr] <= line_wr_data[b*8 +: 8];
      end
      if (bus_en && !bus_rdwr) begin
        word_q[b*8 +: 8] <= ram[bus_line];
      end
      if (line_en && !line_rdwr) begin
        line_rd_data[b*8 +: 8] <= ram[line_addr];
      end
    end
  end

  // software stays off the bus while the engine owns the line port.
  a_no_write_clash: assert property (
    @(posedge clk) disable iff (reset)
    !(bus_en && bus_rdwr && (|bus_mask) && line_en && line_rdwr && bus_line == line_addr)
  );

endmodule

`default_nettype wire

//--- design/gemm_ctrl.sv
`default_nettype none

module gemm_ctrl (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cfg_en,
  input  logic                                cfg_rdwr,
  input  logic [4:0]                          cfg_offset,
  input  logic [31:0]                         cfg_wr_data,
  output logic [31:0]                         cfg_rd_data,
  output logic                                line_en,
  output logic                                line_rdwr,
  output logic [soc_pkg::line_addr_width-1:0] line_addr,
  input  logic [soc_pkg::line_width-1:0]      line_rd_data,
  output logic [soc_pkg::line_width-1:0]      line_wr_data
);
  import soc_pkg::*;

  gemm_state_t                state;
  logic                       busy, done, start;
  logic                       b_phase;   // load_b: issue, then capture.
  logic [3:0]                 step;      // {i, k}.
  logic [1:0]                 i, k;
  logic [line_addr_width-1:0] a_addr, b_addr, c_addr;
  logic [4:0]                 shift;
  logic [line_width-1:0]      a_line, b_line;
  logic                       lane_clear, lane_mac;
  logic [7:0]                 a_elem;
  logic [31:0]                b_row;
  logic [acc_width-1:0]       acc [mat_dim];
  logic                       row_done, line_ready;
  logic [1:0]                 row_index;

  assign busy  = state != st_idle;
  assign start = cfg_en && cfg_rdwr && gemm_reg_t'(cfg_offset) == reg_ctrl &&
                 cfg_wr_data[0] && !busy;
  assign i = step[3:2];
  assign k = step[1:0];

  // configuration registers.
  always_ff @(posedge clk) begin
    if (reset) begin
      a_addr <= '0;
      b_addr <= '0;
      c_addr <= '0;
      shift  <= '0;
    end else if (cfg_en && cfg_rdwr) begin
      case (gemm_reg_t'(cfg_offset))
        reg_a_addr: a_addr <= cfg_wr_data[line_addr_width-1:0];
        reg_b_addr: b_addr <= cfg_wr_data[line_addr_width-1:0];
        reg_c_addr: c_addr <= cfg_wr_data[line_addr_width-1:0];
        reg_shift:  shift  <= cfg_wr_data[4:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    cfg_rd_data = '0;
    case (gemm_reg_t'(cfg_offset))
      reg_status: cfg_rd_data[1:0] = {done, busy};
      reg_a_addr: cfg_rd_data[line_addr_width-1:0] = a_addr;
      reg_b_addr: cfg_rd_data[line_addr_width-1:0] = b_addr;
      reg_c_addr: cfg_rd_data[line_addr_width-1:0] = c_addr;
      reg_shift:  cfg_rd_data[4:0] = shift;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_idle;
      done      <= 1'b0;
      b_phase   <= 1'b0;
      step      <= '0;
      row_done  <= 1'b0;
      row_index <= '0;
    end else begin
      row_done  <= lane_mac && k == 2'd3; // sums final after the k = 3 step.
      row_index <= i;
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_load_a;
            done  <= 1'b0;
          end
        end
        st_load_a: state <= st_load_b;
        st_load_b: begin
          b_phase <= !b_phase;
          if (b_phase) begin
            state <= st_compute;
            step  <= '0;
          end
        end
        st_compute: begin
          step <= step + 4'd1;
          if (step == 4'd15) state <= st_flush;
        end
        st_flush: state <= st_store; // last row in requant.
        st_store: begin
          if (line_ready) begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // A arrives during the first load_b cycle, B during the second.
  always_ff @(posedge clk) begin
    if (state == st_load_b) begin
      if (!b_phase) a_line <= line_rd_data;
      else          b_line <= line_rd_data;
    end
  end

  assign line_en = state == st_load_a || (state == st_load_b && !b_phase) ||
                   (state == st_store && line_ready);
  assign line_rdwr = state == st_store;
  assign line_addr = state == st_load_a ? a_addr :
                     state == st_load_b ? b_addr : c_addr;

  assign lane_mac   = state == st_compute;
  assign lane_clear = k == 2'd0;
  assign a_elem     = a_line[(4*i + k)*8 +: 8]; // A[i][k].
  assign b_row      = b_line[k*32 +: 32];        // row k of B.

  for (genvar j = 0; j < mat_dim; j++) begin : g_lane
    mac_lane u_lane (
      .clk        (clk),
      .reset      (reset),
      .lane_clear (lane_clear),
      .lane_mac   (lane_mac),
      .a_elem     (a_elem),
      .b_byte     (b_row[j*8 +: 8]),
      .acc        (acc[j])
    );
  end

  gemm_requant u_requant (
    .clk          (clk),
    .reset        (reset),
    .row_done     (row_done),
    .row_index    (row_index),
    .shift        (shift),
    .acc0         (acc[0]),
    .acc1         (acc[1]),
    .acc2         (acc[2]),
    .acc3         (acc[3]),
    .line_wr_data (line_wr_data),
    .line_ready   (line_ready)
  );

  a_line_en_state: assert property (
    @(posedge clk) disable iff (reset)
    line_en |-> state inside {st_load_a, st_load_b, st_store}
  );

  // one row every four compute steps at most.
  a_row_done_spacing: assert property (
    @(posedge clk) disable iff (reset)
    row_done |=> !row_done [*3]
  );

endmodule

`default_nettype wire

//--- design/gemm_requant.sv
`default_nettype none

module gemm_requant (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           row_done,
  input  logic [1:0]                     row_index,
  input  logic [4:0]                     shift,
  input  logic [soc_pkg::acc_width-1:0]  acc0,
  input  logic [soc_pkg::acc_width-1:0]  acc1,
  input  logic [soc_pkg::acc_width-1:0]  acc2,
  input  logic [soc_pkg::acc_width-1:0]  acc3,
  output logic [soc_pkg::line_width-1:0] line_wr_data,
  output logic                           line_ready
);
  import soc_pkg::*;

  // arithmetic shift, then clamp to signed 8 bits.
  function automatic logic [7:0] sat8(input logic [acc_width-1:0] a, input logic [4:0] sh);
    logic signed [acc_width-1:0] s;
    s = $signed(a) >>> sh;
    if (s > 127) return 8'h7f;
    else if (s < -128) return 8'h80;
    else return s[7:0];
  endfunction

  always_ff @(posedge clk) begin
    if (row_done) begin
      // byte 4i+j holds C[i][j].
      line_wr_data[row_index*32 +: 32] <= {sat8(acc3, shift), sat8(acc2, shift),
                                           sat8(acc1, shift), sat8(acc0, shift)};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      line_ready <= 1'b0;
    end else if (row_done) begin
      if (row_index == 2'd3) line_ready <= 1'b1;
      else if (row_index == 2'd0) line_ready <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/mac_lane.sv
`default_nettype none

module mac_lane (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          lane_clear,
  input  logic                          lane_mac,
  input  logic [7:0]                    a_elem,
  input  logic [7:0]                    b_byte,
  output logic [soc_pkg::acc_width-1:0] acc
);
  import soc_pkg::*;

  logic signed [15:0]    prod;
  logic [acc_width-1:0]  base;

  assign prod = $signed(a_elem) * $signed(b_byte);
  assign base = lane_clear ? '0 : acc; // first step of a row starts fresh.

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (lane_mac) begin
      acc <= base + {{(acc_width-16){prod[15]}}, prod};
    end
  end

endmodule

`default_nettype wire

//--- design/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // memory geometry.
  localparam int num_banks       = 16;
  localparam int line_addr_width = 11;
  localparam int line_width      = 128;

  // gemm datapath.
  localparam int mat_dim   = 4;
  localparam int acc_width = 32;

  // address regions, bits 31:28 of the bus address.
  localparam logic [3:0] gemm_region = 4'b1001;
  localparam logic [3:0] disp_region = 4'b1010;

  localparam int scan_width = 16; // top three bits pick the digit.

  typedef enum logic [4:0] {
    reg_ctrl   = 5'h00,
    reg_status = 5'h04,
    reg_a_addr = 5'h08,
    reg_b_addr = 5'h0C,
    reg_c_addr = 5'h10,
    reg_shift  = 5'h14
  } gemm_reg_t;

  typedef enum logic [2:0] {
    st_idle,
    st_load_a,
    st_load_b,
    st_compute,
    st_flush,
    st_store
  } gemm_state_t;

endpackage

`default_nettype wire
